/* Makefile */
TOOL     = verilator
TOP      = tb_lsu_backend
FILELIST = filelist.f
FLAGS    = --binary --timing --assert
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_lsu_checks.svh */
`ifndef TB_LSU_CHECKS_SVH
`define TB_LSU_CHECKS_SVH

// ============================================================
// Error counters and compare tasks
// ============================================================

int value_errors   = 0;
int timeout_errors = 0;

task automatic check_data(string name, lsu_pkg::data_t expected, lsu_pkg::data_t actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        value_errors++;
    end
endtask

task automatic check_reg_num(string name, lsu_pkg::reg_num_t expected,
                             lsu_pkg::reg_num_t actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
        value_errors++;
    end
endtask

task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        value_errors++;
    end
endtask

// ============================================================
// Byte model of the data RAM
// ============================================================

logic [7:0] ram_model [4*(2**`RAM_ADDR_BITS)];    // Lane 0 sits at the lowest address.

function automatic lsu_pkg::data_t model_word(lsu_pkg::addr_t addr);
    logic [`RAM_ADDR_BITS-1:0] w;
    w = addr[`RAM_ADDR_BITS+1:2];
    return {ram_model[{w, 2'b11}], ram_model[{w, 2'b10}],
            ram_model[{w, 2'b01}], ram_model[{w, 2'b00}]};
endfunction

task automatic model_store(lsu_pkg::lsu_op_e op, lsu_pkg::addr_t addr, lsu_pkg::data_t data);
    logic [`RAM_ADDR_BITS+1:0] a;
    a = addr[`RAM_ADDR_BITS+1:0];
    case (op)
        lsu_pkg::OP_ST_B: begin
            ram_model[a] = data[7:0];
        end
        lsu_pkg::OP_ST_H: begin
            ram_model[{a[`RAM_ADDR_BITS+1:1], 1'b0}] = data[7:0];
            ram_model[{a[`RAM_ADDR_BITS+1:1], 1'b1}] = data[15:8];
        end
        default: begin
            ram_model[{a[`RAM_ADDR_BITS+1:2], 2'b00}] = data[7:0];
            ram_model[{a[`RAM_ADDR_BITS+1:2], 2'b01}] = data[15:8];
            ram_model[{a[`RAM_ADDR_BITS+1:2], 2'b10}] = data[23:16];
            ram_model[{a[`RAM_ADDR_BITS+1:2], 2'b11}] = data[31:24];
        end
    endcase
endtask

// Architectural load result, built from the bytes at the load address.
function automatic lsu_pkg::data_t expected_load(lsu_pkg::lsu_op_e op, lsu_pkg::addr_t addr);
    logic [`RAM_ADDR_BITS+1:0] a;
    logic [7:0]                b0;
    logic [7:0]                b1;
    a  = addr[`RAM_ADDR_BITS+1:0];
    b0 = ram_model[a];
    b1 = ram_model[{a[`RAM_ADDR_BITS+1:1], 1'b1}];
    case (op)
        lsu_pkg::OP_LD_B:  return {{24{b0[7]}}, b0};
        lsu_pkg::OP_LD_BU: return {24'h0, b0};
        lsu_pkg::OP_LD_H:  return {{16{b1[7]}}, b1, b0};
        lsu_pkg::OP_LD_HU: return {16'h0, b1, b0};
        default:           return model_word(addr);
    endcase
endfunction

`endif

/* dv/tb_lsu_backend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module tb_lsu_backend;
    import lsu_pkg::*;

    logic     clk;
    logic     rst;
    logic     in_valid;
    addr_t    in_pc;
    lsu_op_e  in_op;
    reg_num_t in_rd;
    data_t    in_result;
    data_t    in_store_data;
    reg_num_t rd_num;
    data_t    rd_data;
    logic     wb_rf_wen;
    reg_num_t wb_rf_wnum;
    data_t    wb_rf_wdata;
    addr_t    wb_pc;

    integer seed;
    addr_t  pc_next;
    addr_t  last_pc;

    `include "tb_lsu_checks.svh"

    lsu_backend_top dut0 (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_pc(in_pc), .in_op(in_op),
        .in_rd(in_rd), .in_result(in_result), .in_store_data(in_store_data),
        .rd_num(rd_num), .rd_data(rd_data), .wb_rf_wen(wb_rf_wen),
        .wb_rf_wnum(wb_rf_wnum), .wb_rf_wdata(wb_rf_wdata), .wb_pc(wb_pc)
    );

    always #4 clk = ~clk;

    // ============================================================
    // Driving and waiting
    // ============================================================

    // Called 1 ns after an edge; the op is taken at the next edge.
    task automatic send_op(lsu_op_e op, reg_num_t rd, data_t result, data_t sdata);
        in_valid      = 1'b1;
        in_pc         = pc_next;
        in_op         = op;
        in_rd         = rd;
        in_result     = result;
        in_store_data = sdata;
        last_pc       = pc_next;
        pc_next       = pc_next + 32'd4;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_wen(output logic seen);
        int cycles;
        cycles = 0;
        while (wb_rf_wen !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        seen = (wb_rf_wen === 1'b1);
        if (!seen) begin
            $display("Timeout: no register write showed up within 20 cycles");
            timeout_errors++;
        end
    endtask

    task automatic read_reg(reg_num_t rd, data_t expected);
        rd_num = rd;
        #1;
        check_data($sformatf("rd_data[r%0d]", rd), expected, rd_data);
        @(posedge clk);
        #1;
    endtask

    // Trace is checked in the write-back cycle, the register one cycle later.
    task automatic expect_write(reg_num_t rd, data_t value);
        logic seen;
        wait_wen(seen);
        if (seen) begin
            check_reg_num("wb_rf_wnum", rd, wb_rf_wnum);
            check_data("wb_rf_wdata", value, wb_rf_wdata);
            check_data("wb_pc", last_pc, wb_pc);
        end
        @(posedge clk);
        #1;
        read_reg(rd, (rd == '0) ? 32'h0 : value);
    endtask

    task automatic alu_write(reg_num_t rd, data_t value);
        send_op(OP_ALU, rd, value, 32'h0);
        expect_write(rd, value);
    endtask

    task automatic store_op(lsu_op_e op, addr_t addr, data_t data, reg_num_t rd);
        send_op(op, rd, addr, data);
        check_bit("wb_rf_wen", 1'b0, wb_rf_wen);     // A store never writes a register.
        model_store(op, addr, data);
    endtask

    task automatic load_check(lsu_op_e op, addr_t addr, reg_num_t rd);
        data_t expected;
        expected = expected_load(op, addr);
        send_op(op, rd, addr, 32'h0);
        expect_write(rd, expected);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic reset_state();
        check_bit("wb_rf_wen", 1'b0, wb_rf_wen);
        read_reg(5'd0, 32'h0);
        read_reg(5'd1, 32'h0);
        read_reg(5'd31, 32'h0);
    endtask

    task automatic alu_writeback();
        alu_write(5'd1, $random(seed));
        alu_write(5'd17, $random(seed));
        alu_write(5'd31, $random(seed));
        alu_write(5'd0, 32'hDEAD_BEEF);              // Register 0 stays zero.
    endtask

    task automatic word_store_load();
        store_op(OP_ST_W, 32'h10, $random(seed), 5'd3);
        load_check(OP_LD_W, 32'h10, 5'd4);           // Back to back on the same word.
        store_op(OP_ST_W, 32'h10, $random(seed), 5'd3);
        store_op(OP_ST_W, 32'h10, $random(seed), 5'd3);
        load_check(OP_LD_W, 32'h10, 5'd4);
        for (int i = 0; i < 4; i++) begin
            store_op(OP_ST_W, 32'h20 + 4 * i, $random(seed), 5'd6);
        end
        for (int i = 0; i < 4; i++) begin
            load_check(OP_LD_W, 32'h20 + 4 * i, 5'd7);
        end
    endtask

    task automatic byte_half_stores();
        store_op(OP_ST_W, 32'h40, $random(seed), 5'd0);
        for (int off = 0; off < 4; off++) begin
            store_op(OP_ST_B, 32'h40 + off, $random(seed), 5'd8);
            load_check(OP_LD_W, 32'h40, 5'd5);
        end
        store_op(OP_ST_H, 32'h40, $random(seed), 5'd8);
        load_check(OP_LD_W, 32'h40, 5'd5);
        store_op(OP_ST_H, 32'h42, $random(seed), 5'd8);
        load_check(OP_LD_W, 32'h40, 5'd5);
    endtask

    task automatic load_extension();
        data_t patterns [3];
        patterns[0] = 32'hF283_91A4;                 // Every byte has its top bit set.
        patterns[1] = 32'h1234_5678;
        patterns[2] = $random(seed);
        for (int p = 0; p < 3; p++) begin
            store_op(OP_ST_W, 32'h80, patterns[p], 5'd0);
            for (int off = 0; off < 4; off++) begin
                load_check(OP_LD_B, 32'h80 + off, 5'd10);
                load_check(OP_LD_BU, 32'h80 + off, 5'd11);
                if (off % 2 == 0) begin
                    load_check(OP_LD_H, 32'h80 + off, 5'd12);
                    load_check(OP_LD_HU, 32'h80 + off, 5'd13);
                end
            end
        end
    endtask

    task automatic stores_keep_regs();
        data_t keep;
        keep = $random(seed);
        alu_write(5'd9, keep);
        store_op(OP_ST_W, 32'h100, $random(seed), 5'd9);
        store_op(OP_ST_B, 32'h101, $random(seed), 5'd9);
        store_op(OP_ST_H, 32'h102, $random(seed), 5'd9);
        @(posedge clk);
        #1;
        read_reg(5'd9, keep);
    endtask

    initial begin
        seed          = 32'h22ca36a4;
        pc_next       = 32'h1C00_0000;
        last_pc       = 32'h0;
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b1;                        // Reset has to keep this ALU write out.
        in_pc         = 32'h0;
        in_op         = OP_ALU;
        in_rd         = 5'd1;
        in_result     = 32'hA5A5_5A5A;
        in_store_data = 32'h0;
        rd_num        = '0;
        repeat (8) @(posedge clk);
        #1;
        rst      = 1'b0;
        in_valid = 1'b0;

        reset_state();
        alu_writeback();
        word_store_load();
        byte_half_stores();
        load_extension();
        stores_keep_regs();

        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
+incdir+dv
src/lsu_pkg.sv
src/mem_stage.sv
src/data_ram.sv
src/write_back.sv
src/reg_file.sv
src/lsu_backend_top.sv
dv/tb_lsu_backend.sv

/* src/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module data_ram (
    input  logic                      clk,
    input  logic                      en,
    input  lsu_pkg::ram_be_t          we,
    input  logic [`RAM_ADDR_BITS-1:0] addr,
    input  lsu_pkg::data_t            wdata,
    output lsu_pkg::data_t            rdata
);
    import lsu_pkg::*;

    localparam int DEPTH = 2 ** `RAM_ADDR_BITS;
    localparam int LANES = `DATA_WIDTH / 8;

    data_t mem [DEPTH];

    // ==========================================================
    // Byte-lane write port
    // ==========================================================

    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < LANES; b++) begin
                if (we[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // ==========================================================
    // Registered read port
    // ==========================================================

    // A write and a read of one word on the same edge return the old word.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
        end
    end

    // The memory stage only raises byte enables together with the port enable.
    a_we_needs_en: assert property (@(posedge clk)
        (we != '0) |-> en)
        else $error("data_ram: byte enables 0x%0h without en", we);

endmodule

`default_nettype wire

/* src/lsu_backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_backend_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  lsu_pkg::addr_t    in_pc,
    input  lsu_pkg::lsu_op_e  in_op,
    input  lsu_pkg::reg_num_t in_rd,
    input  lsu_pkg::data_t    in_result,
    input  lsu_pkg::data_t    in_store_data,
    input  lsu_pkg::reg_num_t rd_num,
    output lsu_pkg::data_t    rd_data,
    output logic              wb_rf_wen,
    output lsu_pkg::reg_num_t wb_rf_wnum,
    output lsu_pkg::data_t    wb_rf_wdata,
    output lsu_pkg::addr_t    wb_pc
);
    import lsu_pkg::*;

    // Memory stage to data RAM.
    logic                      ram_en;
    ram_be_t                   ram_we;
    logic [`RAM_ADDR_BITS-1:0] ram_addr;
    data_t                     ram_wdata;
    data_t                     ram_rdata;

    // Memory stage to write-back.
    logic     mem_wb_valid;
    addr_t    mem_wb_pc;
    lsu_op_e  mem_wb_op;
    reg_num_t mem_wb_rd;
    data_t    mem_wb_result;
    logic     mem_wb_is_load;

    // Write-back to register file.
    logic     rf_wen;
    reg_num_t rf_wnum;
    data_t    rf_wdata;

    mem_stage u_mem_stage (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_pc(in_pc), .in_op(in_op), .in_rd(in_rd),
        .in_result(in_result), .in_store_data(in_store_data),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .wb_valid(mem_wb_valid), .wb_pc(mem_wb_pc), .wb_op(mem_wb_op), .wb_rd(mem_wb_rd),
        .wb_result(mem_wb_result), .wb_is_load(mem_wb_is_load)
    );

    data_ram u_data_ram (
        .clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    write_back u_write_back (
        .wb_valid(mem_wb_valid), .wb_pc(mem_wb_pc), .wb_op(mem_wb_op), .wb_rd(mem_wb_rd),
        .wb_result(mem_wb_result), .wb_is_load(mem_wb_is_load), .ram_rdata(ram_rdata),
        .rf_wen(rf_wen), .rf_wnum(rf_wnum), .rf_wdata(rf_wdata),
        .trace_pc(wb_pc), .trace_wen(wb_rf_wen), .trace_wnum(wb_rf_wnum),
        .trace_wdata(wb_rf_wdata)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst),
        .wen(rf_wen), .wnum(rf_wnum), .wdata(rf_wdata),
        .rd_num(rd_num), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

/* src/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// ==========================================================
// Widths of the load/store back end
// ==========================================================

// Data path and register file word.
`define DATA_WIDTH    32

// Byte address and program counter.
`define ADDR_WIDTH    32

// Register number, 32 architectural registers.
`define REG_WIDTH     5

// Word address bits of the data RAM.
`define RAM_ADDR_BITS 8

`endif

/* src/lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    // ==========================================================
    // Data path types
    // ==========================================================

    typedef logic [`DATA_WIDTH-1:0]   data_t;
    typedef logic [`ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`REG_WIDTH-1:0]    reg_num_t;
    typedef logic [`DATA_WIDTH/8-1:0] ram_be_t;     // One bit per byte lane.

    // Bit 2 marks a store, except for the ALU pass-through code.
    typedef enum logic [3:0] {
        OP_LD_B  = 4'b0000,
        OP_LD_H  = 4'b0001,
        OP_LD_W  = 4'b0010,
        OP_ST_B  = 4'b0100,
        OP_ST_H  = 4'b0101,
        OP_ST_W  = 4'b0110,
        OP_LD_BU = 4'b1000,
        OP_LD_HU = 4'b1001,
        OP_ALU   = 4'b1111
    } lsu_op_e;

    function automatic logic op_is_load(lsu_op_e op);
        logic hit;
        case (op)
            OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU: hit = 1'b1;
            default:                                      hit = 1'b0;
        endcase
        return hit;
    endfunction

    function automatic logic op_is_store(lsu_op_e op);
        return op[2] && (op != OP_ALU);
    endfunction

endpackage

`default_nettype wire

/* src/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module mem_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  lsu_pkg::addr_t            in_pc,
    input  lsu_pkg::lsu_op_e          in_op,
    input  lsu_pkg::reg_num_t         in_rd,
    input  lsu_pkg::data_t            in_result,
    input  lsu_pkg::data_t            in_store_data,
    output logic                      ram_en,
    output lsu_pkg::ram_be_t          ram_we,
    output logic [`RAM_ADDR_BITS-1:0] ram_addr,
    output lsu_pkg::data_t            ram_wdata,
    output logic                      wb_valid,
    output lsu_pkg::addr_t            wb_pc,
    output lsu_pkg::lsu_op_e          wb_op,
    output lsu_pkg::reg_num_t         wb_rd,
    output lsu_pkg::data_t            wb_result,
    output logic                      wb_is_load
);
    import lsu_pkg::*;

    logic    is_load;
    logic    is_store;
    ram_be_t lane_be;
    data_t   lane_data;

    // ==========================================================
    // RAM request, presented in the cycle before the edge
    // ==========================================================

    assign is_load  = in_valid && op_is_load(in_op);
    assign is_store = in_valid && op_is_store(in_op);

    // Store data is copied into every lane so the byte enables pick the right one.
    always_comb begin
        case (in_op)
            OP_ST_B: begin
                lane_be   = 4'b0001 << in_result[1:0];
                lane_data = {4{in_store_data[7:0]}};
            end
            OP_ST_H: begin
                lane_be   = in_result[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{in_store_data[15:0]}};
            end
            default: begin
                lane_be   = 4'b1111;
                lane_data = in_store_data;
            end
        endcase
    end

    assign ram_en    = is_load || is_store;
    assign ram_we    = is_store ? lane_be : '0;
    assign ram_addr  = in_result[`RAM_ADDR_BITS+1:2];    // Word address drops the byte offset.
    assign ram_wdata = lane_data;

    // ==========================================================
    // Write-back register
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            wb_pc      <= in_pc;
            wb_op      <= in_op;
            wb_rd      <= in_rd;
            wb_result  <= in_result;                     // Offset bits steer the load shift.
            wb_is_load <= is_load;
        end
    end

    a_st_h_aligned: assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_op == OP_ST_H) |-> !in_result[0])
        else $error("mem_stage: misaligned ST.H at 0x%08h", in_result);

    a_st_w_aligned: assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_op == OP_ST_W) |-> (in_result[1:0] == 2'b00))
        else $error("mem_stage: misaligned ST.W at 0x%08h", in_result);

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              wen,
    input  lsu_pkg::reg_num_t wnum,
    input  lsu_pkg::data_t    wdata,
    input  lsu_pkg::reg_num_t rd_num,
    output lsu_pkg::data_t    rd_data
);
    import lsu_pkg::*;

    localparam int NUM_REGS = 2 ** `REG_WIDTH;

    data_t regs [NUM_REGS];

    // ==========================================================
    // Write port
    // ==========================================================

    // Register 0 is never written, so it keeps its reset value of zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wnum != '0)) begin
            regs[wnum] <= wdata;
        end
    end

    // ==========================================================
    // Read port
    // ==========================================================

    assign rd_data = regs[rd_num];                       // New value shows right after the edge.

endmodule

`default_nettype wire

/* src/write_back.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back (
    input  logic              wb_valid,
    input  lsu_pkg::addr_t    wb_pc,
    input  lsu_pkg::lsu_op_e  wb_op,
    input  lsu_pkg::reg_num_t wb_rd,
    input  lsu_pkg::data_t    wb_result,
    input  logic              wb_is_load,
    input  lsu_pkg::data_t    ram_rdata,
    output logic              rf_wen,
    output lsu_pkg::reg_num_t rf_wnum,
    output lsu_pkg::data_t    rf_wdata,
    output lsu_pkg::addr_t    trace_pc,
    output logic              trace_wen,
    output lsu_pkg::reg_num_t trace_wnum,
    output lsu_pkg::data_t    trace_wdata
);
    import lsu_pkg::*;

    data_t shifted;
    data_t load_value;

    // ==========================================================
    // Load alignment and extension
    // ==========================================================

    // The addressed byte is moved down to lane 0.
    always_comb begin
        case (wb_result[1:0])
            2'b00:   shifted = ram_rdata;
            2'b01:   shifted = {8'b0, ram_rdata[31:8]};
            2'b10:   shifted = {16'b0, ram_rdata[31:16]};
            default: shifted = {24'b0, ram_rdata[31:24]};
        endcase
    end

    always_comb begin
        case (wb_op)
            OP_LD_W:  load_value = shifted;
            OP_LD_B:  load_value = {{24{shifted[7]}}, shifted[7:0]};
            OP_LD_H:  load_value = {{16{shifted[15]}}, shifted[15:0]};
            OP_LD_BU: load_value = {24'b0, shifted[7:0]};
            OP_LD_HU: load_value = {16'b0, shifted[15:0]};
            default:  load_value = wb_result;
        endcase
    end

    // Stores leave the register file alone.
    assign rf_wen   = wb_valid && (wb_is_load || wb_op == OP_ALU);
    assign rf_wnum  = wb_rd;
    assign rf_wdata = wb_is_load ? load_value : wb_result;

    assign trace_pc    = wb_pc;
    assign trace_wen   = rf_wen;
    assign trace_wnum  = rf_wnum;
    assign trace_wdata = rf_wdata;

endmodule

`default_nettype wire
